/* src.f */
+incdir+source
+incdir+verification
source/life_pkg.sv
source/mem_port_if.sv
source/button_debounce.sv
source/seed_loader.sv
source/row_store.sv
source/gen_sequencer.sv
source/cell_rule.sv
source/gen_stats.sv
source/life_top.sv
verification/life_tb.sv

/* verification/life_tb_model.svh */
////////////////////
// Reference grid for the life testbench, seed LFSR and one generation step
////////////////////

row_t ref_grid [`GRID_H];	// Expected cell state
gen_count_t ref_gens;	// Generations applied so far

// Fibonacci LFSR, new top bit from taps 0 2 3 5
function automatic logic [15:0] lfsr_shift(input logic [15:0] v);
	logic fb;
	fb = v[0] ^ v[2] ^ v[3] ^ v[5];
	return (v >> 1) | {fb, 15'd0};
endfunction

task automatic load_seed_rows();
	logic [15:0] v;
	v = `SEED_ROW;
	for (int r = 0; r < `GRID_H; r++) begin
		v = lfsr_shift(v);	// Row r after r+1 advances
		ref_grid[r] = row_t'(v);
	end
	ref_gens = '0;
endtask

// Dead anywhere off the grid
function automatic int cell_at(input int row, input int col);
	if (row < 0 || row >= `GRID_H || col < 0 || col >= `GRID_W)
		return 0;
	return int'(ref_grid[row][col]);
endfunction

task automatic next_generation();
	row_t nxt [`GRID_H];
	int live;
	for (int y = 0; y < `GRID_H; y++) begin
		for (int x = 0; x < `GRID_W; x++) begin
			live = 0;
			for (int dy = -1; dy <= 1; dy++)
				for (int dx = -1; dx <= 1; dx++)
					if (dy != 0 || dx != 0)
						live += cell_at(y + dy, x + dx);	// Eight neighbours
			nxt[y][x] = ref_grid[y][x] ? (live == 2 || live == 3) : (live == 3);
		end
	end
	ref_grid = nxt;
	ref_gens = ref_gens + 1;
endtask

// Step forward until the model matches a generation count
task automatic catch_up_model(input gen_count_t target);
	if (target < ref_gens || target > ref_gens + 4096) begin
		errors++;
		$display("Model cannot follow gen_total %0d from %0d", target, ref_gens);
	end else begin
		while (ref_gens < target)
			next_generation();
	end
endtask

/* verification/life_tb.sv */
////////////////////
// Life engine testbench, random presses and host reads against a grid model
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module life_tb;
	import life_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int N_SHORT = 6;	// Single step presses
	localparam int N_HOLD = 2;	// Plain run mode holds
	localparam int N_REQ = 5;	// Reads issued during a run
	localparam int PASS_CYC = `GRID_H + 3;
	localparam int HOLD_MAX = `LONG_CYCLES + 500;
	localparam int GAP_MAX = `RELEASE_CYCLES + 100;
	localparam int PRESS_WORST = HOLD_MAX + GAP_MAX + `GRID_H * (PASS_CYC + 4) + PASS_CYC;
	localparam int WATCHDOG_CYC = (N_SHORT + N_HOLD + 2) * PRESS_WORST + 4 * `TICKS_PER_SEC;

	logic clk4;
	logic reset;
	logic button;
	logic row_req_valid;
	row_addr_t row_req_addr;
	logic row_req_ready;
	logic row_rsp_valid;
	logic seeded;
	row_t row_rsp_data;
	gen_count_t gen_total;
	rate_t gen_rate;

	int errors;
	int checks;
	int rate_bad;	// Rate mismatches only
	int rate_windows;
	int tick_n;	// Cycles since reset release
	gen_count_t prev_sample;
	gen_count_t last_sample;
	logic acc_d1;	// Accepted request delay line
	logic acc_d2;
	logic [31:0] rng_state;

	`include "life_tb_model.svh"

	life_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk4 = ~clk4;

	////////////////////
	// Helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return lo + int'(rng_state % (hi - lo + 1));
	endfunction

	task automatic check_row(input row_addr_t addr, input row_t got, input row_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: row %0d read %h, expected %h", $time, addr, got, exp);
		end
	endtask

	task automatic check_total(input gen_count_t got, input gen_count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: gen_total %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_rate(input rate_t got, input rate_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			rate_bad++;
			$display("ERROR at %0t: gen_rate %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic press_button(input int high_cycles);
		button <= 1'b1;
		repeat (high_cycles) @(posedge clk4);
		button <= 1'b0;
	endtask

	// One host read, model brought up to the generation seen at the response
	task automatic verify_row(input row_addr_t addr);
		row_req_valid <= 1'b1;
		row_req_addr <= addr;
		@(posedge clk4);
		while (!row_req_ready)
			@(posedge clk4);	// Held while the sequencer is busy
		row_req_valid <= 1'b0;	// Accepted at this edge
		repeat (2) @(posedge clk4);	// Fixed read latency
		catch_up_model(gen_total);
		check_row(addr, row_rsp_data, ref_grid[addr]);
	endtask

	task automatic verify_grid();
		for (int r = 0; r < `GRID_H; r++)
			verify_row(row_addr_t'(r));
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s: %s", name, (errors - rate_bad == err_before) ? "passed" : "failed");
	endtask

	////////////////////
	// Monitors
	always @(posedge clk4) begin
		if (reset) begin
			acc_d1 = 1'b0;
			acc_d2 = 1'b0;
		end else begin
			if (row_rsp_valid && !acc_d2) begin
				errors++;
				$display("Response without a request accepted two cycles earlier at %0t", $time);
			end else if (!row_rsp_valid && acc_d2) begin
				errors++;
				$display("Accepted request got no response two cycles later at %0t", $time);
			end
			acc_d2 = acc_d1;
			acc_d1 = row_req_valid && row_req_ready;
		end
	end

	// Rate window, total sampled on each tick boundary
	always @(posedge clk4) begin
		if (reset) begin
			tick_n = 0;
			prev_sample = '0;
			last_sample = '0;
		end else begin
			tick_n++;
			if (tick_n > 1 && tick_n % `TICKS_PER_SEC == 1) begin
				check_rate(gen_rate, rate_t'(last_sample - prev_sample));	// Visible a cycle late
				rate_windows++;
			end
			if (tick_n % `TICKS_PER_SEC == 0) begin
				prev_sample = last_sample;
				last_sample = gen_total;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk4);
		$display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Stimulus
	initial begin
		int err_before;
		int len;
		int gap;
		gen_count_t prev_total;
		gen_count_t expect_total;
		clk4 = 1'b0;
		reset = 1'b1;
		button = 1'b0;
		row_req_valid = 1'b0;
		row_req_addr = '0;
		errors = 0;
		checks = 0;
		rate_bad = 0;
		rate_windows = 0;
		rng_state = 32'heda55328;
		repeat (5) @(posedge clk4);
		reset <= 1'b0;

		// Seed rows straight from the LFSR
		err_before = errors - rate_bad;
		while (!seeded)
			@(posedge clk4);
		load_seed_rows();
		check_total(gen_total, '0);
		verify_grid();
		report_test("1 seed rows", err_before);

		err_before = errors - rate_bad;
		expect_total = '0;
		for (int i = 0; i < N_SHORT; i++) begin
			len = rand_range(`PRESS_CYCLES + 4, `LONG_CYCLES - 50);	// Well short of a hold
			gap = rand_range(`RELEASE_CYCLES + 10, `RELEASE_CYCLES + 60);
			press_button(len);
			while (gen_total == expect_total)
				@(posedge clk4);
			repeat (gap) @(posedge clk4);	// Debounce back to idle
			expect_total = expect_total + 1;
			check_total(gen_total, expect_total);
			catch_up_model(expect_total);
			verify_grid();
		end
		report_test("2 short presses", err_before);

		err_before = errors - rate_bad;
		for (int i = 0; i < N_HOLD; i++) begin
			len = rand_range(`LONG_CYCLES + 40, HOLD_MAX - 100);
			gap = rand_range(`RELEASE_CYCLES + PASS_CYC + 20, GAP_MAX);
			prev_total = gen_total;
			press_button(len);
			repeat (gap) @(posedge clk4);	// Run mode winds down
			verify_grid();
			if (gen_total < prev_total + 2) begin	// Step plus run mode passes
				errors++;
				$display("Hold of %0d cycles ran no back to back generations", len);
			end
		end
		report_test("3 holds", err_before);

		// Reads held valid against back to back passes
		err_before = errors - rate_bad;
		prev_total = gen_total;
		len = rand_range(`LONG_CYCLES + 300, HOLD_MAX);
		fork
			press_button(len);
			begin
				repeat (`LONG_CYCLES + 20) @(posedge clk4);
				for (int k = 0; k < N_REQ; k++) begin
					verify_row(row_addr_t'(rand_range(0, `GRID_H - 1)));
					repeat (rand_range(5, 30)) @(posedge clk4);
				end
			end
		join
		repeat (GAP_MAX) @(posedge clk4);
		verify_grid();
		if (gen_total < prev_total + 2) begin
			errors++;
			$display("Hold with pending reads ran no back to back generations");
		end
		report_test("4 reads during run mode", err_before);

		while (rate_windows < 3)
			@(posedge clk4);
		$display("test 5 rate windows: %0d compared, %s", rate_windows,
			(rate_bad == 0) ? "passed" : "failed");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* source/life_top.sv */
////////////////////
// Life engine top, button driven with a host row read port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_top (
	input  logic clk4,
	input  logic reset,
	input  logic button,
	input  logic row_req_valid,
	input  life_pkg::row_addr_t row_req_addr,
	output logic row_req_ready,
	output logic row_rsp_valid,
	output logic seeded,
	output life_pkg::row_t row_rsp_data,
	output life_pkg::gen_count_t gen_total,
	output life_pkg::rate_t gen_rate
);
	import life_pkg::*;

	logic step, hold;	// Button commands
	logic seed_valid, seed_ready, seed_done;
	row_t seed_row;
	logic win_shift, next_valid;	// Window handshake
	row_t win_row, next_row;
	logic gen_done;

	mem_port_if mem ();	// Row store ports

	button_debounce _debounce (.clk4(clk4), .reset(reset), .button(button),
		.step(step), .hold(hold));

	seed_loader _seed (.clk4(clk4), .reset(reset), .seed_valid(seed_valid),
		.seed_row(seed_row), .seed_ready(seed_ready), .done(seed_done));

	row_store _store (.clk4(clk4), .mem(mem.store));

	gen_sequencer _seq (
		.clk4(clk4), .reset(reset), .step(step), .hold(hold),
		.seed_valid(seed_valid), .seed_row(seed_row), .seed_ready(seed_ready),
		.seed_done(seed_done), .mem(mem.master),
		.win_shift(win_shift), .win_row(win_row), .next_valid(next_valid),
		.next_row(next_row),
		.row_req_valid(row_req_valid), .row_req_addr(row_req_addr),
		.row_req_ready(row_req_ready), .row_rsp_valid(row_rsp_valid),
		.row_rsp_data(row_rsp_data), .gen_done(gen_done), .seeded(seeded)
	);

	cell_rule _rule (.clk4(clk4), .reset(reset), .win_shift(win_shift),
		.win_row(win_row), .next_valid(next_valid), .next_row(next_row));

	gen_stats _stats (.clk4(clk4), .reset(reset), .gen_done(gen_done),
		.gen_total(gen_total), .gen_rate(gen_rate));

endmodule

`default_nettype wire

/* source/gen_stats.sv */
////////////////////
// Generation counter and per window rate
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module gen_stats (
	input  logic clk4,
	input  logic reset,
	input  logic gen_done,
	output life_pkg::gen_count_t gen_total,
	output life_pkg::rate_t gen_rate
);
	import life_pkg::*;

	localparam int TICK_BITS = $clog2(`TICKS_PER_SEC);

	logic [TICK_BITS-1:0] tick_cnt;	// Window position
	logic tick;
	gen_count_t snap;	// Total at previous tick

	assign tick = (tick_cnt == TICK_BITS'(`TICKS_PER_SEC - 1));

	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_total <= '0;
			gen_rate <= '0;
			tick_cnt <= '0;
			snap <= '0;
		end else begin
			gen_total <= gen_total + gen_count_t'(gen_done);
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick) begin
				gen_rate <= rate_t'(gen_total - snap);	// Gens in the last window
				snap <= gen_total;
			end
		end
	end

endmodule

`default_nettype wire

/* source/cell_rule.sv */
////////////////////
// Three row window and life rule, dead outside the grid
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module cell_rule (
	input  logic clk4,
	input  logic reset,
	input  logic win_shift,
	input  life_pkg::row_t win_row,
	output logic next_valid,
	output life_pkg::row_t next_row
);
	import life_pkg::*;

	row_t above;
	row_t cur;	// Row being updated
	row_t below;
	logic [`ADDR_BITS:0] scnt;	// Shifts this pass, GRID_H+1 per pass

	// Next row from three neighbours rows
	function automatic row_t life_step(input row_t a, input row_t c, input row_t b);
		logic [`GRID_W+1:0] pa;
		logic [`GRID_W+1:0] pc;
		logic [`GRID_W+1:0] pb;
		logic [3:0] n;
		row_t r;
		pa = {1'b0, a, 1'b0};	// Dead columns either side
		pc = {1'b0, c, 1'b0};
		pb = {1'b0, b, 1'b0};
		for (int i = 0; i < `GRID_W; i++) begin
			n = 4'(pa[i]) + 4'(pa[i+1]) + 4'(pa[i+2]) + 4'(pc[i]) + 4'(pc[i+2])
				+ 4'(pb[i]) + 4'(pb[i+1]) + 4'(pb[i+2]);
			r[i] = (n == 4'd3) || (c[i] && n == 4'd2);	// Birth or survival
		end
		return r;
	endfunction

	assign next_row = life_step(above, cur, below);

	// Window shift, first shift of a pass starts from dead rows
	always_ff @(posedge clk4) begin
		if (win_shift) begin
			above <= (scnt == '0) ? '0 : cur;
			cur <= (scnt == '0) ? '0 : below;
			below <= win_row;
		end
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			scnt <= '0;
			next_valid <= 1'b0;
		end else begin
			next_valid <= win_shift && (scnt != '0);	// cur holds a real row
			if (win_shift)
				scnt <= (scnt == `GRID_H) ? '0 : scnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/gen_sequencer.sv */
////////////////////
// Row store arbiter, runs seeding, host reads and generation passes
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module gen_sequencer (
	input  logic clk4,
	input  logic reset,
	input  logic step,
	input  logic hold,
	input  logic seed_valid,
	input  life_pkg::row_t seed_row,
	output logic seed_ready,
	input  logic seed_done,
	mem_port_if.master mem,
	output logic win_shift,
	output life_pkg::row_t win_row,
	input  logic next_valid,
	input  life_pkg::row_t next_row,
	input  logic row_req_valid,
	input  life_pkg::row_addr_t row_req_addr,
	output logic row_req_ready,
	output logic row_rsp_valid,
	output life_pkg::row_t row_rsp_data,
	output logic gen_done,
	output logic seeded
);
	import life_pkg::*;

	localparam int PASS_LAST = `GRID_H + 2;	// Cycle of the last write

	typedef enum logic [1:0] {ST_SEED, ST_IDLE, ST_HOST, ST_PASS} seq_state_t;

	seq_state_t state;
	logic [`ADDR_BITS+1:0] cnt;	// Pass cycle
	row_addr_t wcnt;	// Next row to write
	logic pend;	// Step waiting for a pass
	logic go;
	logic accept;
	logic rd_q;	// Read slot one cycle back
	logic dead_q;	// Slot past the last row
	logic [1:0] rsp_pipe;	// Host read in flight

	assign seed_ready = (state == ST_SEED);
	assign row_req_ready = (state == ST_IDLE) && seeded && !rsp_pipe[1];
	assign accept = row_req_valid && row_req_ready;
	assign go = (pend || hold) && !row_req_valid;	// Host reads go first
	assign row_rsp_valid = rsp_pipe[1];

	// Store ports
	assign mem.re = accept || (state == ST_PASS && cnt < `GRID_H);
	assign mem.raddr = (state == ST_PASS) ? row_addr_t'(cnt) : row_req_addr;
	assign mem.we = (state == ST_SEED) ? (seed_valid && seed_ready) : next_valid;
	assign mem.waddr = wcnt;
	assign mem.wdata = (state == ST_SEED) ? seed_row : next_row;

	assign win_shift = rd_q;
	assign win_row = dead_q ? '0 : mem.rdata;	// Dead row below the grid

	////////////////////
	// Control FSM
	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= ST_SEED;
			cnt <= '0;
			pend <= 1'b0;
			seeded <= 1'b0;
			gen_done <= 1'b0;
		end else begin
			gen_done <= 1'b0;
			if (step)
				pend <= 1'b1;
			case (state)
				ST_SEED: begin
					if (seed_done) begin
						state <= ST_IDLE;
						seeded <= 1'b1;
					end
				end
				ST_IDLE: begin
					if (accept) begin
						state <= ST_HOST;
					end else if (go) begin
						state <= ST_PASS;
						cnt <= '0;
						pend <= step;	// Consumed unless a new press arrives
					end
				end
				ST_HOST: if (rsp_pipe[0]) state <= ST_IDLE;
				ST_PASS: begin
					cnt <= cnt + 1'b1;
					if (cnt == PASS_LAST) begin
						gen_done <= 1'b1;
						cnt <= '0;
						if (go)
							pend <= step;	// Back to back
						else
							state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////
	// Write pointer, window strobes, host pipe
	always_ff @(posedge clk4) begin
		if (reset) begin
			wcnt <= '0;
			rd_q <= 1'b0;
			dead_q <= 1'b0;
			rsp_pipe <= '0;
		end else begin
			if (mem.we)
				wcnt <= (wcnt == row_addr_t'(`GRID_H - 1)) ? '0 : wcnt + 1'b1;
			rd_q <= (state == ST_PASS) && (cnt <= `GRID_H);
			dead_q <= (state == ST_PASS) && (cnt == `GRID_H);
			rsp_pipe <= {rsp_pipe[0], accept};
		end
	end

	always_ff @(posedge clk4) begin
		if (rsp_pipe[0])
			row_rsp_data <= mem.rdata;
	end

	// Writeback stays behind the read of the row below
	assert property (@(posedge clk4) disable iff (reset)
		(state == ST_PASS && mem.we) |-> (int'(mem.waddr) + 1 < int'(cnt)));

endmodule

`default_nettype wire

/* source/row_store.sv */
////////////////////
// Cell memory, one row per entry, registered read
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module row_store (
	input  logic clk4,
	mem_port_if.store mem
);
	import life_pkg::*;

	row_t cells [`GRID_H];	// Grid body

	// Write port
	always_ff @(posedge clk4) begin
		if (mem.we)
			cells[mem.waddr] <= mem.wdata;
	end

	// Read port, returns old data on a same cycle write
	always_ff @(posedge clk4) begin
		if (mem.re)
			mem.rdata <= cells[mem.raddr];
	end

endmodule

`default_nettype wire

/* source/seed_loader.sv */
////////////////////
// Seed source, LFSR rows handed to the sequencer after reset
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module seed_loader (
	input  logic clk4,
	input  logic reset,
	output logic seed_valid,
	output life_pkg::row_t seed_row,
	input  logic seed_ready,
	output logic done	// All rows handed over
);
	import life_pkg::*;

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	row_addr_t idx;	// Row being offered

	// Fibonacci shift toward bit 0, taps 0 2 3 5
	assign lfsr_next = {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
	assign seed_row = row_t'(lfsr_next);	// Row r is value after r+1 steps
	assign seed_valid = !done;

	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr <= `SEED_ROW;
			idx <= '0;
			done <= 1'b0;
		end else if (seed_valid && seed_ready) begin
			lfsr <= lfsr_next;
			idx <= idx + 1'b1;
			if (idx == row_addr_t'(`GRID_H - 1))
				done <= 1'b1;	// Last row taken
		end
	end

	assert property (@(posedge clk4) disable iff (reset) lfsr != '0);

endmodule

`default_nettype wire

/* source/button_debounce.sv */
////////////////////
// Button debounce, classifies presses into step and hold
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "life_defs.svh"

module button_debounce (
	input  logic clk4,
	input  logic reset,
	input  logic button,
	output logic step,	// One pulse per press
	output logic hold	// Level while held long
);
	import life_pkg::*;

	localparam int CNT_BITS = $clog2(`LONG_CYCLES + 1);
	localparam int REL_BITS = $clog2(`RELEASE_CYCLES + 1);

	logic [2:0] sync;	// Metastability chain
	logic btn;
	btn_state_t state;
	btn_state_t state_next;
	logic [CNT_BITS-1:0] press_cnt;	// Cycles since press began
	logic [REL_BITS-1:0] rel_cnt;	// Cycles low

	assign btn = sync[2];
	assign hold = (state == BTN_LONG) || (state == BTN_WAIT_LOFF);

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			BTN_IDLE: if (btn) state_next = BTN_WAIT_PRESS;
			BTN_WAIT_PRESS: begin
				if (!btn)
					state_next = BTN_IDLE;	// Glitch
				else if (press_cnt == CNT_BITS'(`PRESS_CYCLES))
					state_next = BTN_WAIT_PULSE;
			end
			BTN_WAIT_PULSE: if (press_cnt == CNT_BITS'(`PULSE_CYCLES)) state_next = BTN_WAIT_LONG;
			BTN_WAIT_LONG: begin
				if (!btn)
					state_next = BTN_WAIT_OFF;
				else if (press_cnt >= CNT_BITS'(`LONG_CYCLES))
					state_next = BTN_LONG;
			end
			BTN_LONG: if (!btn) state_next = BTN_WAIT_LOFF;
			BTN_WAIT_OFF: begin
				if (btn)
					state_next = BTN_WAIT_LONG;	// Bounce, keep the press
				else if (rel_cnt == REL_BITS'(`RELEASE_CYCLES))
					state_next = BTN_IDLE;
			end
			BTN_WAIT_LOFF: begin
				if (btn)
					state_next = BTN_LONG;
				else if (rel_cnt == REL_BITS'(`RELEASE_CYCLES))
					state_next = BTN_IDLE;
			end
			default: state_next = BTN_IDLE;
		endcase
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			sync <= '0;
			state <= BTN_IDLE;
			press_cnt <= '0;
			rel_cnt <= '0;
			step <= 1'b0;
		end else begin
			sync <= {sync[1:0], button};
			state <= state_next;
			step <= (state_next == BTN_WAIT_PULSE) && (state != BTN_WAIT_PULSE);	// Entry pulse
			if (state == BTN_IDLE)
				press_cnt <= '0;
			else if (press_cnt != CNT_BITS'(`LONG_CYCLES))
				press_cnt <= press_cnt + 1'b1;	// Saturates at long time
			rel_cnt <= (state == BTN_WAIT_OFF || state == BTN_WAIT_LOFF) ? rel_cnt + 1'b1 : '0;
		end
	end

	// Run mode always follows the step, never overlaps it
	assert property (@(posedge clk4) disable iff (reset) !(step && hold));

endmodule

`default_nettype wire

/* source/mem_port_if.sv */
////////////////////
// Row store port bundle
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
	import life_pkg::*;

	logic re;	// Read strobe
	row_addr_t raddr;
	row_t rdata;	// Valid the cycle after re
	logic we;	// Write strobe
	row_addr_t waddr;
	row_t wdata;

	// Sequencer side
	modport master (output re, raddr, we, waddr, wdata, input rdata);

	// Memory side
	modport store (input re, raddr, we, waddr, wdata, output rdata);

endinterface

`default_nettype wire

/* source/life_pkg.sv */
////////////////////
// Life engine types shared across blocks
////////////////////
`default_nettype none
`include "life_defs.svh"

package life_pkg;

	// One grid row, bit i is column i
	typedef logic [`GRID_W-1:0] row_t;

	typedef logic [`ADDR_BITS-1:0] row_addr_t;	// Row index

	// Progress counters
	typedef logic [31:0] gen_count_t;	// Total generations
	typedef logic [15:0] rate_t;	// Generations per window

	// Button classifier states
	typedef enum logic [2:0] {
		BTN_IDLE,
		BTN_WAIT_PRESS,	// High, not yet long enough
		BTN_WAIT_PULSE,	// Step issued, riding out the pulse
		BTN_WAIT_LONG,
		BTN_LONG,	// Run mode
		BTN_WAIT_OFF,
		BTN_WAIT_LOFF	// Released from run mode
	} btn_state_t;

endpackage

`default_nettype wire

/* source/life_defs.svh */
////////////////////
// Life engine constants for grid, button timing and rate window
////////////////////
`ifndef LIFE_DEFS_SVH
`define LIFE_DEFS_SVH

// Grid geometry
`define GRID_W 16
`define GRID_H 16
`define ADDR_BITS 4	// log2 of GRID_H

// Button timing in clk4 cycles
`define PRESS_CYCLES 8	// Min high time for a press
`define PULSE_CYCLES 20	// Press committed as one step
`define LONG_CYCLES 200	// Held this long becomes run mode
`define RELEASE_CYCLES 40	// Low time back to idle

// Rate window in clk4 cycles
`define TICKS_PER_SEC 1000

// Seed LFSR start, never zero
`define SEED_ROW 16'hace1

`endif
